//--- common/hist_pkg.sv
package hist_pkg;

    typedef logic [31:0] word_t;       // histogram word, also the axi data word
    typedef logic [19:0] page_num_t;   // 4 KB page number in system memory
    typedef logic [31:0] sys_addr_t;   // system byte address
    typedef logic [1:0]  sensor_t;     // sensor channel index
    typedef logic [1:0]  color_t;      // colour, same as page position in a session
    typedef logic [7:0]  page_addr_t;  // word address inside one buffer page
    typedef logic [3:0]  table_idx_t;  // {sensor, sub channel}

    localparam int NUM_SENSORS    = 4;
    localparam int NUM_PAGES      = 4;    // buffer pages and pages per session
    localparam int WORDS_PER_PAGE = 256;
    localparam int BURST_LEN      = 16;   // words per axi write burst

    // register map, 0..15 are start-page table entries
    localparam logic [4:0] REG_MODE_ADDR = 5'd16;
    localparam int         MODE_EN_BIT   = 0;

    typedef enum logic [2:0] {
        BLK_IDLE,
        BLK_LOAD_ATTR,
        BLK_CALC_ADDR,
        BLK_RUN,
        BLK_DRAIN
    } block_state_t;

endpackage

//--- hw/hist_arbiter.sv
module hist_arbiter import hist_pkg::*; #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      nreset_aclk,
    input  logic                      en,
    input  logic [NUM_SENSORS-1:0]    hist_request,
    input  logic [NUM_SENSORS-1:0]    hist_dvalid,
    output logic [NUM_SENSORS-1:0]    hist_grant,
    input  logic [1:0]                hist_chn0,
    input  logic [1:0]                hist_chn1,
    input  logic [1:0]                hist_chn2,
    input  logic [1:0]                hist_chn3,
    input  logic [NUM_FRAME_BITS-1:0] frame0,
    input  logic [NUM_FRAME_BITS-1:0] frame1,
    input  logic [NUM_FRAME_BITS-1:0] frame2,
    input  logic [NUM_FRAME_BITS-1:0] frame3,
    input  word_t                     hist_data0,
    input  word_t                     hist_data1,
    input  word_t                     hist_data2,
    input  word_t                     hist_data3,
    input  logic                      buf_full,
    output logic                      wr_en,
    output word_t                     wr_data,
    output sensor_t                   wr_sensor,
    output color_t                    wr_sub_chn,
    output logic [NUM_FRAME_BITS-1:0] wr_frame
);

    word_t                     data_in  [NUM_SENSORS];
    color_t                    chn_in   [NUM_SENSORS];
    logic [NUM_FRAME_BITS-1:0] frame_in [NUM_SENSORS];
    logic                      busy;       // session active
    sensor_t                   sel;        // sensor owning the session
    sensor_t                   req_pick;
    color_t                    page_cnt;   // pages finished in this session
    logic                      dav_sel;
    logic                      page_end;

    assign data_in  = '{hist_data0, hist_data1, hist_data2, hist_data3};
    assign chn_in   = '{hist_chn0, hist_chn1, hist_chn2, hist_chn3};
    assign frame_in = '{frame0, frame1, frame2, frame3};

    // lowest index wins
    always_comb begin
        req_pick = '0;
        for (int i = NUM_SENSORS - 1; i >= 0; i--) begin
            if (hist_request[i]) req_pick = sensor_t'(i);
        end
    end

    assign dav_sel  = busy && hist_dvalid[sel];
    assign page_end = wr_en && !dav_sel;  // last word is in the data register

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            busy       <= 1'b0;
            sel        <= '0;
            page_cnt   <= '0;
            wr_en      <= 1'b0;
            hist_grant <= '0;
        end else begin
            wr_en <= dav_sel;
            if (!busy && |hist_request) begin
                busy     <= 1'b1;  // no preemption until the session ends
                sel      <= req_pick;
                page_cnt <= '0;
            end else if (page_end) begin
                page_cnt <= page_cnt + 1'b1;
                if (page_cnt == color_t'(NUM_PAGES - 1)) busy <= 1'b0;  // release after 4th page
            end
            hist_grant      <= '0;
            hist_grant[sel] <= busy && !buf_full && hist_request[sel];
        end
    end

    // hold attributes of the last valid word so they survive to the page end
    always_ff @(posedge mclk) begin
        if (dav_sel) begin
            wr_data    <= data_in[sel];
            wr_sensor  <= sel;
            wr_sub_chn <= chn_in[sel];
            wr_frame   <= frame_in[sel];
        end
    end

endmodule

//--- hw/hist_regs.sv
module hist_regs import hist_pkg::*; (
    input  logic       mclk,
    input  logic       nreset_aclk,
    input  logic [4:0] cmd_addr,
    input  word_t      cmd_data,
    input  logic       cmd_we,
    output logic       en,
    input  table_idx_t table_idx,
    output page_num_t  start_page
);

    page_num_t start_table [16];  // start page per {sensor, sub channel}

    always_ff @(posedge mclk) begin
        if (!nreset_aclk) begin
            en <= 1'b0;
        end else if (cmd_we && cmd_addr == REG_MODE_ADDR) begin
            en <= cmd_data[MODE_EN_BIT];
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_we && cmd_addr < REG_MODE_ADDR) begin
            start_table[cmd_addr[3:0]] <= page_num_t'(cmd_data);  // low 20 bits only
        end
        start_page <= start_table[table_idx];  // registered lookup, one cycle
    end

endmodule

//--- hw/histogram_saxi.sv
module histogram_saxi import hist_pkg::*; #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      nreset_aclk,
    input  logic [NUM_FRAME_BITS-1:0] frame0,
    input  logic                      hist_request0,
    output logic                      hist_grant0,
    input  logic [1:0]                hist_chn0,
    input  logic                      hist_dvalid0,
    input  word_t                     hist_data0,
    input  logic [NUM_FRAME_BITS-1:0] frame1,
    input  logic                      hist_request1,
    output logic                      hist_grant1,
    input  logic [1:0]                hist_chn1,
    input  logic                      hist_dvalid1,
    input  word_t                     hist_data1,
    input  logic [NUM_FRAME_BITS-1:0] frame2,
    input  logic                      hist_request2,
    output logic                      hist_grant2,
    input  logic [1:0]                hist_chn2,
    input  logic                      hist_dvalid2,
    input  word_t                     hist_data2,
    input  logic [NUM_FRAME_BITS-1:0] frame3,
    input  logic                      hist_request3,
    output logic                      hist_grant3,
    input  logic [1:0]                hist_chn3,
    input  logic                      hist_dvalid3,
    input  word_t                     hist_data3,
    input  logic [4:0]                cmd_addr,
    input  word_t                     cmd_data,
    input  logic                      cmd_we,
    output sys_addr_t                 saxi_awaddr,
    output logic                      saxi_awvalid,
    input  logic                      saxi_awready,
    output word_t                     saxi_wdata,
    output logic                      saxi_wvalid,
    input  logic                      saxi_wready,
    output logic                      saxi_wlast
);

    logic                      en;
    logic                      buf_full;
    logic                      page_avail;
    logic                      page_sent;
    logic                      page_start;
    logic                      bursts_done;
    logic                      wr_en;
    word_t                     wr_data;
    sensor_t                   wr_sensor;
    color_t                    wr_sub_chn;
    logic [NUM_FRAME_BITS-1:0] wr_frame;
    logic                      rd_en;
    page_addr_t                rd_addr;
    word_t                     rd_data;
    table_idx_t                rd_table_idx;
    logic [NUM_FRAME_BITS-1:0] rd_frame;
    color_t                    rd_color;
    table_idx_t                table_idx;
    page_num_t                 start_page;

    hist_regs i_regs (
        .mclk        (mclk),
        .nreset_aclk (nreset_aclk),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_we      (cmd_we),
        .en          (en),
        .table_idx   (table_idx),
        .start_page  (start_page)
    );

    hist_arbiter #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) i_arbiter (
        .mclk         (mclk),
        .nreset_aclk  (nreset_aclk),
        .en           (en),
        .hist_request ({hist_request3, hist_request2, hist_request1, hist_request0}),
        .hist_dvalid  ({hist_dvalid3, hist_dvalid2, hist_dvalid1, hist_dvalid0}),
        .hist_grant   ({hist_grant3, hist_grant2, hist_grant1, hist_grant0}),
        .hist_chn0    (hist_chn0),
        .hist_chn1    (hist_chn1),
        .hist_chn2    (hist_chn2),
        .hist_chn3    (hist_chn3),
        .frame0       (frame0),
        .frame1       (frame1),
        .frame2       (frame2),
        .frame3       (frame3),
        .hist_data0   (hist_data0),
        .hist_data1   (hist_data1),
        .hist_data2   (hist_data2),
        .hist_data3   (hist_data3),
        .buf_full     (buf_full),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_sensor    (wr_sensor),
        .wr_sub_chn   (wr_sub_chn),
        .wr_frame     (wr_frame)
    );

    page_buffer #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) i_page_buffer (
        .mclk         (mclk),
        .nreset_aclk  (nreset_aclk),
        .en           (en),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_sensor    (wr_sensor),
        .wr_sub_chn   (wr_sub_chn),
        .wr_frame     (wr_frame),
        .buf_full     (buf_full),
        .page_avail   (page_avail),
        .page_sent    (page_sent),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_table_idx (rd_table_idx),
        .rd_frame     (rd_frame),
        .rd_color     (rd_color)
    );

    saxi_block_ctrl #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) i_block_ctrl (
        .mclk         (mclk),
        .nreset_aclk  (nreset_aclk),
        .en           (en),
        .page_avail   (page_avail),
        .rd_table_idx (rd_table_idx),
        .rd_frame     (rd_frame),
        .rd_color     (rd_color),
        .table_idx    (table_idx),
        .start_page   (start_page),
        .page_start   (page_start),
        .bursts_done  (bursts_done),
        .page_sent    (page_sent),
        .saxi_awaddr  (saxi_awaddr),
        .saxi_awvalid (saxi_awvalid),
        .saxi_awready (saxi_awready)
    );

    saxi_wdata i_wdata (
        .mclk        (mclk),
        .nreset_aclk (nreset_aclk),
        .en          (en),
        .page_start  (page_start),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .bursts_done (bursts_done),
        .saxi_wdata  (saxi_wdata),
        .saxi_wvalid (saxi_wvalid),
        .saxi_wready (saxi_wready),
        .saxi_wlast  (saxi_wlast)
    );

endmodule

//--- hw/page_buffer.sv
module page_buffer import hist_pkg::*; #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      nreset_aclk,
    input  logic                      en,
    input  logic                      wr_en,
    input  word_t                     wr_data,
    input  sensor_t                   wr_sensor,
    input  color_t                    wr_sub_chn,
    input  logic [NUM_FRAME_BITS-1:0] wr_frame,
    output logic                      buf_full,
    output logic                      page_avail,
    input  logic                      page_sent,
    input  logic                      rd_en,
    input  page_addr_t                rd_addr,
    output word_t                     rd_data,
    output table_idx_t                rd_table_idx,
    output logic [NUM_FRAME_BITS-1:0] rd_frame,
    output color_t                    rd_color
);

    word_t                     mem        [NUM_PAGES * WORDS_PER_PAGE];
    word_t                     mem_q;       // first read stage
    table_idx_t                attr_idx   [NUM_PAGES];
    logic [NUM_FRAME_BITS-1:0] attr_frame [NUM_PAGES];
    color_t                    attr_color [NUM_PAGES];
    color_t                    wr_page;
    color_t                    rd_page;
    page_addr_t                wr_addr;
    logic                      wr_en_d;
    logic                      page_begin;
    logic                      page_written;
    logic [2:0]                pages_held;  // started and not yet sent, 0..4
    logic [2:0]                pages_done;  // complete and not yet sent

    assign page_begin   = wr_en && !wr_en_d;
    assign page_written = wr_en_d && !wr_en;  // falling edge closes the page

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            wr_en_d    <= 1'b0;
            wr_page    <= '0;
            wr_addr    <= '0;
            rd_page    <= '0;
            pages_held <= '0;
            pages_done <= '0;
        end else begin
            wr_en_d <= wr_en;
            if (wr_en) wr_addr <= wr_addr + 1'b1;  // wraps to 0 after 256 words
            if (page_written) wr_page <= wr_page + 1'b1;
            if (page_sent) rd_page <= rd_page + 1'b1;
            pages_held <= pages_held + 3'(page_begin) - 3'(page_sent);
            pages_done <= pages_done + 3'(page_written) - 3'(page_sent);
        end
    end

    always_ff @(posedge mclk) begin
        if (wr_en) mem[{wr_page, wr_addr}] <= wr_data;
        if (page_written) begin
            attr_idx[wr_page]   <= {wr_sensor, wr_sub_chn};
            attr_frame[wr_page] <= wr_frame;
            attr_color[wr_page] <= wr_page;  // sessions are 4 pages so page slot = colour
        end
        if (rd_en) mem_q <= mem[{rd_page, rd_addr}];
        rd_data <= mem_q;  // valid 2 cycles after rd_en
    end

    // counting started pages keeps the grant off before a busy slot is reused
    assign buf_full     = pages_held == 3'(NUM_PAGES);
    assign page_avail   = pages_done != '0;
    assign rd_table_idx = attr_idx[rd_page];
    assign rd_frame     = attr_frame[rd_page];
    assign rd_color     = attr_color[rd_page];

endmodule

//--- run_sim.sh
#!/bin/sh
# builds and runs the histogram testbench with Verilator, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_histogram_saxi -o tb_sim
./obj_dir/tb_sim

//--- saxi/saxi_block_ctrl.sv
module saxi_block_ctrl import hist_pkg::*; #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      nreset_aclk,
    input  logic                      en,
    input  logic                      page_avail,
    input  table_idx_t                rd_table_idx,
    input  logic [NUM_FRAME_BITS-1:0] rd_frame,
    input  color_t                    rd_color,
    output table_idx_t                table_idx,
    input  page_num_t                 start_page,
    output logic                      page_start,
    input  logic                      bursts_done,
    output logic                      page_sent,
    output sys_addr_t                 saxi_awaddr,
    output logic                      saxi_awvalid,
    input  logic                      saxi_awready
);

    localparam int BURSTS_PER_PAGE = WORDS_PER_PAGE / BURST_LEN;

    block_state_t              state;
    logic                      lookup_done;  // start_page valid for table_idx
    logic                      data_done;    // all 16 data bursts accepted
    logic [3:0]                burst_cnt;
    logic [NUM_FRAME_BITS-1:0] frame_r;
    color_t                    color_r;
    page_num_t                 page_sum;

    assign page_sum     = start_page + page_num_t'(frame_r);
    assign saxi_awvalid = state == BLK_RUN;
    assign page_start   = state == BLK_LOAD_ATTR;
    // combinational so the buffer drops the page before idle looks again
    assign page_sent    = state == BLK_DRAIN && (data_done || bursts_done);

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            state       <= BLK_IDLE;
            lookup_done <= 1'b0;
            data_done   <= 1'b0;
            burst_cnt   <= '0;
        end else begin
            if (page_sent) data_done <= 1'b0;
            else if (bursts_done) data_done <= 1'b1;  // data may finish before addresses
            case (state)
                BLK_IDLE: begin
                    if (page_avail) state <= BLK_LOAD_ATTR;
                end
                BLK_LOAD_ATTR: begin
                    lookup_done <= 1'b0;
                    state       <= BLK_CALC_ADDR;
                end
                BLK_CALC_ADDR: begin
                    lookup_done <= 1'b1;  // wait one cycle for the table read
                    if (lookup_done) begin
                        burst_cnt <= '0;
                        state     <= BLK_RUN;
                    end
                end
                BLK_RUN: begin
                    if (saxi_awready) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        if (burst_cnt == 4'(BURSTS_PER_PAGE - 1)) state <= BLK_DRAIN;
                    end
                end
                BLK_DRAIN: begin
                    if (page_sent) state <= BLK_IDLE;
                end
                default: state <= BLK_IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (state == BLK_LOAD_ATTR) begin
            table_idx <= rd_table_idx;
            frame_r   <= rd_frame;
            color_r   <= rd_color;
        end
        // (start_page + frame) * 4096 + colour * 1024
        if (state == BLK_CALC_ADDR) begin
            saxi_awaddr <= {page_sum, color_r, 10'b0};
        end else if (saxi_awvalid && saxi_awready) begin
            saxi_awaddr <= saxi_awaddr + sys_addr_t'(BURST_LEN * 4);  // next 64 byte burst
        end
    end

endmodule

//--- saxi/saxi_wdata.sv
module saxi_wdata import hist_pkg::*; (
    input  logic       mclk,
    input  logic       nreset_aclk,
    input  logic       en,
    input  logic       page_start,
    output logic       rd_en,
    output page_addr_t rd_addr,
    input  word_t      rd_data,
    output logic       bursts_done,
    output word_t      saxi_wdata,
    output logic       saxi_wvalid,
    input  logic       saxi_wready,
    output logic       saxi_wlast
);

    localparam int FIFO_DEPTH = 4;

    word_t      fifo_mem [FIFO_DEPTH];
    logic [1:0] fifo_wp;
    logic [1:0] fifo_rp;
    logic [2:0] fifo_cnt;
    logic       fifo_push;
    logic       fifo_pop;
    logic       run;        // page readout in progress
    logic [1:0] rd_pipe;    // tracks the 2 cycle buffer read latency
    logic [3:0] beat_cnt;   // words in the current burst
    logic [3:0] burst_cnt;  // bursts in the current page

    // pause at half full, two reads in flight still fit
    assign rd_en       = run && fifo_cnt < 3'(FIFO_DEPTH / 2);
    assign fifo_push   = rd_pipe[1];
    assign saxi_wvalid = fifo_cnt != '0;
    assign fifo_pop    = saxi_wvalid && saxi_wready;
    assign saxi_wdata  = fifo_mem[fifo_rp];
    assign saxi_wlast  = saxi_wvalid && beat_cnt == 4'(BURST_LEN - 1);

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            run         <= 1'b0;
            rd_addr     <= '0;
            rd_pipe     <= '0;
            fifo_wp     <= '0;
            fifo_rp     <= '0;
            fifo_cnt    <= '0;
            beat_cnt    <= '0;
            burst_cnt   <= '0;
            bursts_done <= 1'b0;
        end else begin
            rd_pipe <= {rd_pipe[0], rd_en};
            if (page_start) begin
                run     <= 1'b1;
                rd_addr <= '0;
            end else if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == page_addr_t'(WORDS_PER_PAGE - 1)) run <= 1'b0;
            end
            if (fifo_push) fifo_wp <= fifo_wp + 1'b1;
            if (fifo_pop) fifo_rp <= fifo_rp + 1'b1;
            fifo_cnt <= fifo_cnt + 3'(fifo_push) - 3'(fifo_pop);
            if (fifo_pop) beat_cnt <= beat_cnt + 1'b1;
            bursts_done <= 1'b0;
            if (fifo_pop && saxi_wlast) begin
                burst_cnt   <= burst_cnt + 1'b1;
                bursts_done <= burst_cnt == 4'(WORDS_PER_PAGE / BURST_LEN - 1);  // 16th wlast
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (fifo_push) fifo_mem[fifo_wp] <= rd_data;
    end

endmodule

//--- src.f
common/hist_pkg.sv
hw/hist_regs.sv
hw/hist_arbiter.sv
hw/page_buffer.sv
saxi/saxi_block_ctrl.sv
saxi/saxi_wdata.sv
hw/histogram_saxi.sv
verification/tb_histogram_saxi.sv

//--- verification/hist_input.txt
# W addr data: register write, 00-0f start table {sensor, sub channel}, 10 mode
# S sensor sub_chn frame delay: session, G runs the group, N s: held request, R aw% w%
W 10 00000000
N 2
W 01 00000100
W 06 00012340
W 08 000fffff
W 0f fff80000
W 10 00000001
R 100 100
S 1 2 5 0
G
R 70 70
S 3 3 15 0
S 2 0 3 0
S 1 2 6 0
S 0 1 2 0
G
R 60 20
S 3 3 1 0
S 2 0 9 4
S 0 1 7 30
G

//--- verification/tb_histogram_saxi.sv
module tb_histogram_saxi import hist_pkg::*; ();

    localparam int WAIT_LIMIT = 40000;  // cycles for three sessions behind a slow wready

    logic       mclk = 1'b0;
    logic       nreset_aclk;
    logic [3:0] request;
    logic [3:0] dvalid;
    logic [3:0] grant;
    logic [1:0] chn   [NUM_SENSORS];
    logic [3:0] frame [NUM_SENSORS];
    word_t      data  [NUM_SENSORS];
    logic [4:0] cmd_addr;
    word_t      cmd_data;
    logic       cmd_we;
    sys_addr_t  saxi_awaddr;
    logic       saxi_awvalid;
    logic       saxi_awready = 1'b0;
    word_t      saxi_wdata;
    logic       saxi_wvalid;
    logic       saxi_wready = 1'b0;
    logic       saxi_wlast;

    page_num_t  start_tab  [16];  // model of the start-page table
    word_t      sess_words [NUM_SENSORS][NUM_PAGES * WORDS_PER_PAGE];
    word_t      exp_data   [$];   // all words in expected memory order
    sys_addr_t  exp_addr   [$];
    int         exp_order  [$];   // sensors in expected grant order
    logic       grp_on     [NUM_SENSORS];
    int         grp_chn    [NUM_SENSORS];
    int         grp_frame  [NUM_SENSORS];
    int         grp_delay  [NUM_SENSORS];
    int         aw_pct = 100;     // awready probability in percent
    int         w_pct = 100;
    int         data_rd = 0;      // next expected word
    int         addr_rd = 0;
    int         order_rd;
    int         word_cnt = 0;     // accepted words over the whole run
    int         pages_started;
    int         pages_accepted = 0;
    logic       held_off;         // a sensor waited while 4 pages were held
    logic       aw_wait = 1'b0;   // address offered and not yet taken
    sys_addr_t  aw_hold;

    always #20 mclk = ~mclk;

    histogram_saxi #(.NUM_FRAME_BITS(4)) i_dut (
        .mclk          (mclk),
        .nreset_aclk   (nreset_aclk),
        .frame0        (frame[0]),
        .hist_request0 (request[0]),
        .hist_grant0   (grant[0]),
        .hist_chn0     (chn[0]),
        .hist_dvalid0  (dvalid[0]),
        .hist_data0    (data[0]),
        .frame1        (frame[1]),
        .hist_request1 (request[1]),
        .hist_grant1   (grant[1]),
        .hist_chn1     (chn[1]),
        .hist_dvalid1  (dvalid[1]),
        .hist_data1    (data[1]),
        .frame2        (frame[2]),
        .hist_request2 (request[2]),
        .hist_grant2   (grant[2]),
        .hist_chn2     (chn[2]),
        .hist_dvalid2  (dvalid[2]),
        .hist_data2    (data[2]),
        .frame3        (frame[3]),
        .hist_request3 (request[3]),
        .hist_grant3   (grant[3]),
        .hist_chn3     (chn[3]),
        .hist_dvalid3  (dvalid[3]),
        .hist_data3    (data[3]),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .cmd_we        (cmd_we),
        .saxi_awaddr   (saxi_awaddr),
        .saxi_awvalid  (saxi_awvalid),
        .saxi_awready  (saxi_awready),
        .saxi_wdata    (saxi_wdata),
        .saxi_wvalid   (saxi_wvalid),
        .saxi_wready   (saxi_wready),
        .saxi_wlast    (saxi_wlast)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input word_t value);
        @(negedge mclk);
        cmd_addr = addr;
        cmd_data = value;
        cmd_we   = 1'b1;
        @(negedge mclk);
        cmd_we = 1'b0;
        if (addr < 5'd16) start_tab[addr[3:0]] = value[19:0];  // table keeps 20 bits
    endtask

    // request held with en low must never see a grant
    task automatic check_no_grant(input int s);
        request[s] = 1'b1;
        repeat (100) begin
            @(negedge mclk);
            check_value("hist_grant", 0, grant);
            check_value("saxi_awvalid", 0, saxi_awvalid);
            check_value("saxi_wvalid", 0, saxi_wvalid);
        end
        request[s] = 1'b0;
    endtask

    // random words and 64 burst addresses of one session appended in grant order
    task automatic add_session(input int s);
        sys_addr_t pg;
        exp_order.push_back(s);
        for (int i = 0; i < NUM_PAGES * WORDS_PER_PAGE; i++) begin
            sess_words[s][i] = $urandom;
            exp_data.push_back(sess_words[s][i]);
        end
        pg = sys_addr_t'(start_tab[s * 4 + grp_chn[s]]) + sys_addr_t'(grp_frame[s] & 15);
        for (int i = 0; i < 64; i++) begin
            exp_addr.push_back((pg << 12) + sys_addr_t'(i / 16 * 1024)  // colour = page in session
                               + sys_addr_t'(i % 16 * 64));
        end
    endtask

    task automatic sensor_session(input int s);
        int cnt;
        if (grp_on[s]) begin
            repeat (grp_delay[s]) @(negedge mclk);
            chn[s]     = 2'(grp_chn[s]);
            frame[s]   = 4'(grp_frame[s]);
            request[s] = 1'b1;
            for (int p = 0; p < NUM_PAGES; p++) begin
                cnt = 0;
                @(negedge mclk);  // dvalid stays low at least one cycle between pages
                while (!grant[s]) begin
                    if (pages_started - pages_accepted == NUM_PAGES) held_off = 1'b1;
                    cnt++;
                    if (cnt > WAIT_LIMIT) begin
                        $display("timeout: sensor %0d waited %0d cycles without a grant",
                                 s, WAIT_LIMIT);
                        abort_run();
                    end
                    @(negedge mclk);
                end
                if (p == 0) begin
                    check_value("granted sensor", exp_order[order_rd], s);
                    order_rd++;
                end
                if (pages_started - pages_accepted >= NUM_PAGES) begin
                    $display("sensor %0d was granted a page while 4 pages were held", s);
                    abort_run();
                end
                pages_started++;
                for (int i = 0; i < WORDS_PER_PAGE; i++) begin
                    dvalid[s] = 1'b1;
                    data[s]   = sess_words[s][p * WORDS_PER_PAGE + i];
                    @(negedge mclk);
                end
                dvalid[s] = 1'b0;
                if (p == NUM_PAGES - 1) request[s] = 1'b0;  // session done
            end
        end
    endtask

    task automatic run_group();
        int first;
        int cnt;
        first = -1;
        for (int i = 0; i < NUM_SENSORS; i++) begin
            if (grp_on[i] && (first < 0 || grp_delay[i] < grp_delay[first])) first = i;
        end
        // earliest request opens the bus and the rest go lowest index first
        if (first >= 0) add_session(first);
        for (int i = 0; i < NUM_SENSORS; i++) begin
            if (grp_on[i] && i != first) add_session(i);
        end
        fork
            sensor_session(0);
            sensor_session(1);
            sensor_session(2);
            sensor_session(3);
        join
        cnt = 0;
        while (data_rd < exp_data.size() || addr_rd < exp_addr.size()) begin
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("timeout: memory writes not complete after %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(posedge mclk);  // counters move on the falling edge only
        end
        for (int i = 0; i < NUM_SENSORS; i++) grp_on[i] = 1'b0;
    endtask

    // memory side responder and checker deciding the transfers of the next rising edge
    always @(negedge mclk) begin
        saxi_awready = ($urandom % 100) < aw_pct;
        saxi_wready  = ($urandom % 100) < w_pct;
        if (aw_wait) begin
            check_value("saxi_awvalid", 1, saxi_awvalid);  // must hold until taken
            check_value("saxi_awaddr", aw_hold, saxi_awaddr);
        end
        aw_wait = saxi_awvalid && !saxi_awready;
        aw_hold = saxi_awaddr;
        if (saxi_awvalid && saxi_awready) begin
            if (addr_rd >= exp_addr.size()) begin
                $display("write address %h arrived with no burst expected", saxi_awaddr);
                abort_run();
            end else begin
                check_value("saxi_awaddr", exp_addr[addr_rd], saxi_awaddr);
                addr_rd++;
            end
        end
        if (saxi_wvalid && saxi_wready) begin
            if (data_rd >= exp_data.size()) begin
                $display("write data %h arrived with no word expected", saxi_wdata);
                abort_run();
            end else begin
                check_value("saxi_wdata", exp_data[data_rd], saxi_wdata);
                check_value("saxi_wlast", word_cnt % BURST_LEN == BURST_LEN - 1, saxi_wlast);
                if (word_cnt % WORDS_PER_PAGE == WORDS_PER_PAGE - 1) pages_accepted++;
                data_rd++;
                word_cnt++;
            end
        end
    end

    initial begin
        int               fd;
        int               code;
        int               done;
        int               s;
        int               c;
        int               f;
        int               dl;
        int               seed_val;
        logic [31:0]      a;
        word_t            d;
        logic [63:0]      tag;
        logic [8*128-1:0] line;
        seed_val      = $urandom(32'h9d13_60e2);
        nreset_aclk   = 1'b0;
        request       = '0;
        dvalid        = '0;
        cmd_addr      = '0;
        cmd_data      = '0;
        cmd_we        = 1'b0;
        order_rd      = 0;
        pages_started = 0;
        held_off      = 1'b0;
        for (int i = 0; i < NUM_SENSORS; i++) begin
            chn[i]    = '0;
            frame[i]  = '0;
            data[i]   = '0;
            grp_on[i] = 1'b0;
        end
        repeat (10) @(negedge mclk);
        nreset_aclk = 1'b1;
        repeat (20) begin  // quiet outputs after reset
            @(negedge mclk);
            check_value("hist_grant", 0, grant);
            check_value("saxi_awvalid", 0, saxi_awvalid);
            check_value("saxi_wvalid", 0, saxi_wvalid);
            check_value("saxi_wlast", 0, saxi_wlast);
        end
        fd = $fopen("verification/hist_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/hist_input.txt");
            abort_run();
        end
        done = 0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1;
            end else if (tag == "#") begin
                code = $fgets(line, fd);  // comment line
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h", a, d);
                write_reg(a[4:0], d);
            end else if (tag == "N") begin
                code = $fscanf(fd, "%d", s);
                check_no_grant(s);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %d", aw_pct, w_pct);
            end else if (tag == "S") begin
                code = $fscanf(fd, "%d %d %d %d", s, c, f, dl);
                grp_on[s]    = 1'b1;
                grp_chn[s]   = c;
                grp_frame[s] = f;
                grp_delay[s] = dl;
            end else if (tag == "G") begin
                run_group();
            end else begin
                $display("unknown line type %s in verification/hist_input.txt", tag);
                abort_run();
            end
        end
        $fclose(fd);
        repeat (50) @(negedge mclk);  // any late transfer is caught by the checker
        check_value("saxi_awvalid", 0, saxi_awvalid);
        check_value("saxi_wvalid", 0, saxi_wvalid);
        check_value("grant held off at full buffer", 1, held_off);
        $display("Everything OK");
        $finish;
    end

endmodule
